//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PCIe TLP bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_pcie_tlp_bridge
OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR"
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

if [ ! -x "$OBJ_DIR/V$TOP" ]; then
    echo "Simulation executable not found"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

//--- src/pcie_link_ctrl.sv
`timescale 1ns/1ps

module pcie_link_ctrl (
    input  logic i_clk_pcie,
    input  logic i_rst,

    // Reset sources
    input  logic i_perst_n,
    input  logic i_user_reset,
    input  logic i_soft_rst_subsys,
    input  logic i_soft_rst_core,

    // Link status
    input  logic i_user_lnk_up,

    output logic o_rst_subsys,
    output logic o_core_rst_n,
    output logic o_led_state
);

    logic                                 rst_subsys_q;
    logic                                 core_rst_n_q;
    logic [tlp_stream_pkg::LED_CNT_W-1:0] led_cnt;

    // --------------------
    // Reset combination
    // --------------------

    // Board reset forces both outputs into reset
    always_ff @(posedge i_clk_pcie) begin
        if (i_rst) begin
            rst_subsys_q <= 1'b1;
            core_rst_n_q <= 1'b0;
        end else begin
            // Subsystem follows the core user reset and its soft reset
            rst_subsys_q <= i_user_reset || i_soft_rst_subsys;

            // Core held in reset by PERST# or its own soft reset
            core_rst_n_q <= i_perst_n && !i_soft_rst_core;
        end
    end

    assign o_rst_subsys = rst_subsys_q;
    assign o_core_rst_n = core_rst_n_q;

    // --------------------
    // Link and activity LED
    // --------------------

    // Free-running, only the top bit is visible
    always_ff @(posedge i_clk_pcie) begin
        if (i_rst) begin
            led_cnt <= '0;
        end else begin
            led_cnt <= led_cnt + 1'b1;
        end
    end

    // Solid while the link is up, blinking otherwise
    assign o_led_state = i_user_lnk_up || led_cnt[tlp_stream_pkg::LED_BLINK_BIT];

endmodule

//--- src/pcie_tlp_bridge.sv
`timescale 1ns/1ps

module pcie_tlp_bridge (
    input  logic                                   i_clk_pcie,
    input  logic                                   i_rst,

    // Reset and link control
    input  logic                                   i_perst_n,
    input  logic                                   i_user_reset,
    input  logic                                   i_soft_rst_subsys,
    input  logic                                   i_soft_rst_core,
    input  logic                                   i_user_lnk_up,
    output logic                                   o_core_rst_n,
    output logic                                   o_led_state,

    // Core receive stream
    input  logic [tlp_stream_pkg::CORE_DATA_W-1:0] i_core_rx_data,
    input  logic [tlp_stream_pkg::CORE_KEEP_W-1:0] i_core_rx_keep,
    input  logic                                   i_core_rx_last,
    input  logic                                   i_core_rx_valid,
    input  logic [tlp_stream_pkg::CORE_USER_W-1:0] i_core_rx_user,
    output logic                                   o_core_rx_ready,

    // User receive stream
    output tlp_stream_pkg::tlp_word_t              o_rx_tdata,
    output logic [tlp_stream_pkg::TLP_DW_N-1:0]    o_rx_tkeepdw,
    output logic                                   o_rx_tfirst,
    output logic                                   o_rx_tlast,
    output logic [tlp_stream_pkg::BAR_HIT_W-1:0]   o_rx_bar_hit,
    output logic                                   o_rx_tvalid,

    // User transmit stream
    input  tlp_stream_pkg::tlp_word_t              i_tx_tdata,
    input  logic [tlp_stream_pkg::TLP_DW_N-1:0]    i_tx_tkeepdw,
    input  logic                                   i_tx_tlast,
    input  logic                                   i_tx_tvalid,
    output logic                                   o_tx_tready,

    // Core transmit stream
    output logic [tlp_stream_pkg::CORE_DATA_W-1:0] o_core_tx_data,
    output logic [tlp_stream_pkg::CORE_KEEP_W-1:0] o_core_tx_keep,
    output logic                                   o_core_tx_last,
    output logic                                   o_core_tx_valid,
    input  logic                                   i_core_tx_ready
);

    logic rst_subsys;

    pcie_link_ctrl u_link_ctrl (
        .i_clk_pcie        (i_clk_pcie),
        .i_rst             (i_rst),
        .i_perst_n         (i_perst_n),
        .i_user_reset      (i_user_reset),
        .i_soft_rst_subsys (i_soft_rst_subsys),
        .i_soft_rst_core   (i_soft_rst_core),
        .i_user_lnk_up     (i_user_lnk_up),
        .o_rst_subsys      (rst_subsys),
        .o_core_rst_n      (o_core_rst_n),
        .o_led_state       (o_led_state)
    );

    // 64 to 128 bit receive
    tlp_rx_packer u_rx_packer (
        .i_clk_pcie      (i_clk_pcie),
        .i_rst           (rst_subsys),
        .i_core_rx_data  (i_core_rx_data),
        .i_core_rx_keep  (i_core_rx_keep),
        .i_core_rx_last  (i_core_rx_last),
        .i_core_rx_valid (i_core_rx_valid),
        .i_core_rx_user  (i_core_rx_user),
        .o_core_rx_ready (o_core_rx_ready),
        .o_rx_tdata      (o_rx_tdata),
        .o_rx_tkeepdw    (o_rx_tkeepdw),
        .o_rx_tfirst     (o_rx_tfirst),
        .o_rx_tlast      (o_rx_tlast),
        .o_rx_bar_hit    (o_rx_bar_hit),
        .o_rx_tvalid     (o_rx_tvalid)
    );

    // 128 to 64 bit transmit
    tlp_tx_splitter u_tx_splitter (
        .i_clk_pcie      (i_clk_pcie),
        .i_rst           (rst_subsys),
        .i_tx_tdata      (i_tx_tdata),
        .i_tx_tkeepdw    (i_tx_tkeepdw),
        .i_tx_tlast      (i_tx_tlast),
        .i_tx_tvalid     (i_tx_tvalid),
        .o_tx_tready     (o_tx_tready),
        .o_core_tx_data  (o_core_tx_data),
        .o_core_tx_keep  (o_core_tx_keep),
        .o_core_tx_last  (o_core_tx_last),
        .o_core_tx_valid (o_core_tx_valid),
        .i_core_tx_ready (i_core_tx_ready)
    );

endmodule

//--- src/tlp_rx_packer.sv
`timescale 1ns/1ps

module tlp_rx_packer (
    input  logic                                   i_clk_pcie,
    input  logic                                   i_rst,

    // Core receive stream
    input  logic [tlp_stream_pkg::CORE_DATA_W-1:0] i_core_rx_data,
    input  logic [tlp_stream_pkg::CORE_KEEP_W-1:0] i_core_rx_keep,
    input  logic                                   i_core_rx_last,
    input  logic                                   i_core_rx_valid,
    input  logic [tlp_stream_pkg::CORE_USER_W-1:0] i_core_rx_user,
    output logic                                   o_core_rx_ready,

    // User TLP receive stream
    output tlp_stream_pkg::tlp_word_t              o_rx_tdata,
    output logic [tlp_stream_pkg::TLP_DW_N-1:0]    o_rx_tkeepdw,
    output logic                                   o_rx_tfirst,
    output logic                                   o_rx_tlast,
    output logic [tlp_stream_pkg::BAR_HIT_W-1:0]   o_rx_bar_hit,
    output logic                                   o_rx_tvalid
);

    tlp_stream_pkg::tlp_word_t                  rx_word;
    logic                                       first_q;
    logic                                       last_q;
    logic [2:0]                                 len_q;
    logic [tlp_stream_pkg::BAR_HIT_W-1:0]       bar_hit_q;

    logic                                       beat_done;
    logic                                       two_dw;
    logic [2:0]                                 next_base;
    logic [2:0]                                 next_len;
    logic [1:0]                                 base_idx;

    // --------------------
    // Beat completion
    // --------------------

    // A beat goes out on last, or once three or more dwords are held
    assign beat_done = last_q || (len_q > 3'd2);

    // Upper half of the core keep marks a two-dword beat
    assign two_dw = i_core_rx_keep[tlp_stream_pkg::CORE_KEEP_W/2];

    // Restart at dword 0 when the held beat is being emitted
    assign next_base = beat_done ? 3'd0 : len_q;
    assign next_len  = next_base + 3'd1 + {2'b00, two_dw};
    assign base_idx  = next_base[1:0];

    // No back-pressure toward the core
    assign o_core_rx_ready = 1'b1;

    // --------------------
    // Control state
    // --------------------

    always_ff @(posedge i_clk_pcie) begin
        if (i_rst) begin
            first_q   <= 1'b1;
            last_q    <= 1'b0;
            len_q     <= 3'd0;
            bar_hit_q <= '0;
        end else if (i_core_rx_valid) begin
            // First re-arms only after the last beat of a TLP leaves
            if (beat_done) begin
                first_q <= last_q;
            end
            last_q    <= i_core_rx_last;
            len_q     <= next_len;
            bar_hit_q <= i_core_rx_user[tlp_stream_pkg::BAR_HIT_LSB +: tlp_stream_pkg::BAR_HIT_W];
        end else if (beat_done) begin
            first_q   <= last_q;
            last_q    <= 1'b0;
            len_q     <= 3'd0;
            bar_hit_q <= '0;
        end
    end

    // --------------------
    // Data assembly
    // --------------------

    // Core qword lands at the current dword offset
    always_ff @(posedge i_clk_pcie) begin
        if (i_core_rx_valid) begin
            rx_word.dw[base_idx] <= i_core_rx_data[31:0];
            if (two_dw) begin
                rx_word.dw[base_idx + 2'd1] <= i_core_rx_data[63:32];
            end
        end
    end

    // Output strobe follows the completing core beat by one cycle
    assign o_rx_tdata   = rx_word;
    assign o_rx_tkeepdw = {(len_q > 3'd3), (len_q > 3'd2), (len_q > 3'd1), 1'b1};
    assign o_rx_tfirst  = first_q;
    assign o_rx_tlast   = last_q;
    assign o_rx_bar_hit = bar_hit_q;
    assign o_rx_tvalid  = beat_done;

endmodule

//--- src/tlp_stream_pkg.sv
package tlp_stream_pkg;

    // --------------------
    // Stream widths
    // --------------------

    // 64-bit hard-core stream
    localparam int CORE_DATA_W = 64;
    localparam int CORE_KEEP_W = 8;

    // 128-bit user TLP stream
    localparam int TLP_DATA_W = 128;
    localparam int TLP_DW_N   = 4;

    // Receive user word from the core, BAR hit sits at bits 8:2
    localparam int CORE_USER_W = 22;
    localparam int BAR_HIT_W   = 7;
    localparam int BAR_HIT_LSB = 2;

    // --------------------
    // Core keep codes
    // --------------------

    // Only the low dword of the qword is valid
    localparam logic [CORE_KEEP_W-1:0] KEEP_ONE_DW = 8'h0f;

    // Both dwords valid
    localparam logic [CORE_KEEP_W-1:0] KEEP_TWO_DW = 8'hff;

    // --------------------
    // LED blink counter
    // --------------------

    localparam int LED_CNT_W     = 26;
    localparam int LED_BLINK_BIT = 25;

    // --------------------
    // 128-bit TLP word
    // --------------------

    // The receive packer fills the word one dword at a time,
    // the transmit splitter drains it one qword at a time.
    // Dword 0 and qword 0 both sit in the low bits.
    typedef union packed {
        logic [TLP_DW_N-1:0][TLP_DATA_W/TLP_DW_N-1:0]                dw;
        logic [TLP_DATA_W/CORE_DATA_W-1:0][CORE_DATA_W-1:0]          qw;
    } tlp_word_t;

endpackage

//--- src/tlp_tx_splitter.sv
`timescale 1ns/1ps

module tlp_tx_splitter (
    input  logic                                   i_clk_pcie,
    input  logic                                   i_rst,

    // User TLP transmit stream
    input  tlp_stream_pkg::tlp_word_t              i_tx_tdata,
    input  logic [tlp_stream_pkg::TLP_DW_N-1:0]    i_tx_tkeepdw,
    input  logic                                   i_tx_tlast,
    input  logic                                   i_tx_tvalid,
    output logic                                   o_tx_tready,

    // Core transmit stream
    output logic [tlp_stream_pkg::CORE_DATA_W-1:0] o_core_tx_data,
    output logic [tlp_stream_pkg::CORE_KEEP_W-1:0] o_core_tx_keep,
    output logic                                   o_core_tx_last,
    output logic                                   o_core_tx_valid,
    input  logic                                   i_core_tx_ready
);

    // Pending high qword of a 3-4 dword beat
    logic                                   pend_valid;
    logic [tlp_stream_pkg::CORE_DATA_W-1:0] pend_data;
    logic                                   pend_last;
    logic                                   pend_two_dw;

    logic                                   out_two_dw;
    logic                                   load_high;

    // --------------------
    // Output select
    // --------------------

    assign out_two_dw = pend_valid ? pend_two_dw : i_tx_tkeepdw[1];

    assign o_core_tx_valid = pend_valid || i_tx_tvalid;
    assign o_core_tx_data  = pend_valid ? pend_data : i_tx_tdata.qw[0];

    // Low half of a split beat never closes the TLP
    assign o_core_tx_last = pend_valid ? pend_last : (i_tx_tlast && !i_tx_tkeepdw[2]);
    assign o_core_tx_keep = out_two_dw ? tlp_stream_pkg::KEEP_TWO_DW
                                       : tlp_stream_pkg::KEEP_ONE_DW;

    // Input stalls while the high qword waits for the core
    assign o_tx_tready = i_core_tx_ready && !pend_valid;

    // Low half of a wide beat taken by the core
    assign load_high = !pend_valid && i_tx_tvalid && i_core_tx_ready && i_tx_tkeepdw[2];

    // --------------------
    // Pending qword
    // --------------------

    always_ff @(posedge i_clk_pcie) begin
        if (i_rst) begin
            pend_valid <= 1'b0;
        end else if (load_high) begin
            pend_valid <= 1'b1;
        end else if (pend_valid && i_core_tx_ready) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk_pcie) begin
        if (load_high) begin
            pend_data   <= i_tx_tdata.qw[1];
            pend_last   <= i_tx_tlast;
            pend_two_dw <= i_tx_tkeepdw[3];
        end
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk_pcie,
    output logic o_rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 16;

    initial begin
        o_clk_pcie = 1'b0;
        forever #HALF_PERIOD o_clk_pcie = ~o_clk_pcie;
    end

    // Reset released on a rising edge like any other input
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk_pcie);
        o_rst <= 1'b0;
    end

endmodule

//--- verif/tb_pcie_tlp_bridge.sv
`timescale 1ns/1ps

module tb_pcie_tlp_bridge;

    localparam int TIMEOUT = 2000;

    logic clk_pcie;
    logic rst;

    logic i_perst_n, i_user_reset, i_soft_rst_subsys, i_soft_rst_core, i_user_lnk_up;
    logic o_core_rst_n, o_led_state;
    logic [63:0] i_core_rx_data;
    logic [7:0]  i_core_rx_keep;
    logic        i_core_rx_last, i_core_rx_valid;
    logic [21:0] i_core_rx_user;
    logic        o_core_rx_ready;
    tlp_stream_pkg::tlp_word_t o_rx_tdata;
    logic [3:0]  o_rx_tkeepdw;
    logic        o_rx_tfirst, o_rx_tlast, o_rx_tvalid;
    logic [6:0]  o_rx_bar_hit;
    tlp_stream_pkg::tlp_word_t i_tx_tdata;
    logic [3:0]  i_tx_tkeepdw;
    logic        i_tx_tlast, i_tx_tvalid, o_tx_tready;
    logic [63:0] o_core_tx_data;
    logic [7:0]  o_core_tx_keep;
    logic        o_core_tx_last, o_core_tx_valid, i_core_tx_ready;

    int errors = 0;
    int tests_run = 0;
    int errors_at_start = 0;
    logic [31:0] rng_stim = 32'h0d33ac22;
    logic [31:0] rng_ready = 32'h0d33ac22 ^ 32'h5a5a5a5a;
    bit bp_mode = 1'b0;

    // Receive model state
    bit          sub_rst_m = 1'b1;
    logic [31:0] acc_dw [4];
    int          acc_cnt = 0;
    bit          model_first = 1'b1;
    bit          exp_rx_valid = 1'b0;
    logic [31:0] exp_dw [4];
    int          exp_cnt;
    bit          exp_first, exp_last;
    logic [6:0]  exp_bar;

    // Transmit model state
    logic [63:0] exp_tx_data [$];
    logic [7:0]  exp_tx_keep [$];
    bit          exp_tx_last [$];
    bit          prev_stall = 1'b0;
    logic [63:0] prev_data;
    logic [7:0]  prev_keep;
    logic        prev_last;

    tb_clock u_clock (
        .o_clk_pcie (clk_pcie),
        .o_rst      (rst)
    );

    pcie_tlp_bridge uut (
        .i_clk_pcie (clk_pcie), .i_rst (rst),
        .i_perst_n (i_perst_n), .i_user_reset (i_user_reset),
        .i_soft_rst_subsys (i_soft_rst_subsys), .i_soft_rst_core (i_soft_rst_core),
        .i_user_lnk_up (i_user_lnk_up), .o_core_rst_n (o_core_rst_n),
        .o_led_state (o_led_state),
        .i_core_rx_data (i_core_rx_data), .i_core_rx_keep (i_core_rx_keep),
        .i_core_rx_last (i_core_rx_last), .i_core_rx_valid (i_core_rx_valid),
        .i_core_rx_user (i_core_rx_user), .o_core_rx_ready (o_core_rx_ready),
        .o_rx_tdata (o_rx_tdata), .o_rx_tkeepdw (o_rx_tkeepdw),
        .o_rx_tfirst (o_rx_tfirst), .o_rx_tlast (o_rx_tlast),
        .o_rx_bar_hit (o_rx_bar_hit), .o_rx_tvalid (o_rx_tvalid),
        .i_tx_tdata (i_tx_tdata), .i_tx_tkeepdw (i_tx_tkeepdw),
        .i_tx_tlast (i_tx_tlast), .i_tx_tvalid (i_tx_tvalid), .o_tx_tready (o_tx_tready),
        .o_core_tx_data (o_core_tx_data), .o_core_tx_keep (o_core_tx_keep),
        .o_core_tx_last (o_core_tx_last), .o_core_tx_valid (o_core_tx_valid),
        .i_core_tx_ready (i_core_tx_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_stim = xorshift32(rng_stim);
        return rng_stim;
    endfunction

    task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] got);
        $display("[FAIL] %s expected %h got %h", name, exp, got);
        errors++;
    endtask

    task automatic report_error(string what);
        $display("Error: %s", what);
        errors++;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        $display("%s done, %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // --------------------
    // Reference models and checks
    // --------------------

    always @(posedge clk_pcie) begin
        int n;
        int nt;
        if (sub_rst_m) begin
            acc_cnt = 0;
            model_first = 1'b1;
            exp_rx_valid = 1'b0;
            prev_stall = 1'b0;
            exp_tx_data.delete();
            exp_tx_keep.delete();
            exp_tx_last.delete();
        end else begin
            // No back-pressure toward the core
            assert (o_core_rx_ready === 1'b1)
                else report_mismatch("o_core_rx_ready", 1, o_core_rx_ready);

            // Receive beat exactly one cycle after its completing core beat
            assert (o_rx_tvalid === exp_rx_valid)
                else report_mismatch("o_rx_tvalid", exp_rx_valid, o_rx_tvalid);
            if (exp_rx_valid && o_rx_tvalid === 1'b1) begin
                for (int i = 0; i < exp_cnt; i++) begin
                    assert (o_rx_tdata.dw[i] === exp_dw[i])
                        else report_mismatch("o_rx_tdata", exp_dw[i], o_rx_tdata.dw[i]);
                end
                assert (o_rx_tkeepdw === 4'((1 << exp_cnt) - 1))
                    else report_mismatch("o_rx_tkeepdw", (1 << exp_cnt) - 1, o_rx_tkeepdw);
                assert (o_rx_tfirst === exp_first)
                    else report_mismatch("o_rx_tfirst", exp_first, o_rx_tfirst);
                assert (o_rx_tlast === exp_last)
                    else report_mismatch("o_rx_tlast", exp_last, o_rx_tlast);
                assert (o_rx_bar_hit === exp_bar)
                    else report_mismatch("o_rx_bar_hit", exp_bar, o_rx_bar_hit);
            end
            exp_rx_valid = 1'b0;
            if (i_core_rx_valid) begin
                n = i_core_rx_keep[4] ? 2 : 1;
                acc_dw[acc_cnt] = i_core_rx_data[31:0];
                if (n == 2) begin
                    acc_dw[acc_cnt + 1] = i_core_rx_data[63:32];
                end
                acc_cnt += n;
                exp_bar = i_core_rx_user[tlp_stream_pkg::BAR_HIT_LSB
                                         +: tlp_stream_pkg::BAR_HIT_W];
                if (i_core_rx_last || acc_cnt > 2) begin
                    exp_dw = acc_dw;
                    exp_cnt = acc_cnt;
                    exp_first = model_first;
                    exp_last = i_core_rx_last;
                    exp_rx_valid = 1'b1;
                    model_first = i_core_rx_last;
                    acc_cnt = 0;
                end
            end

            // A queued core beat here is the pending high qword
            assert (o_tx_tready === (i_core_tx_ready && exp_tx_data.size() == 0))
                else report_mismatch("o_tx_tready",
                                     i_core_tx_ready && exp_tx_data.size() == 0,
                                     o_tx_tready);

            // Accepted user beat becomes one or two core beats
            if (i_tx_tvalid && o_tx_tready) begin
                nt = i_tx_tkeepdw[3] ? 4 : i_tx_tkeepdw[2] ? 3 : i_tx_tkeepdw[1] ? 2 : 1;
                exp_tx_data.push_back(i_tx_tdata.qw[0]);
                exp_tx_keep.push_back(nt >= 2 ? 8'hff : 8'h0f);
                exp_tx_last.push_back(nt <= 2 ? i_tx_tlast : 1'b0);
                if (nt > 2) begin
                    exp_tx_data.push_back(i_tx_tdata.qw[1]);
                    exp_tx_keep.push_back(nt == 4 ? 8'hff : 8'h0f);
                    exp_tx_last.push_back(i_tx_tlast);
                end
            end
            if (prev_stall) begin
                assert (o_core_tx_valid === 1'b1)
                    else report_error("core transmit beat withdrawn before acceptance");
                assert (o_core_tx_data === prev_data)
                    else report_mismatch("o_core_tx_data", prev_data, o_core_tx_data);
                assert (o_core_tx_keep === prev_keep)
                    else report_mismatch("o_core_tx_keep", prev_keep, o_core_tx_keep);
                assert (o_core_tx_last === prev_last)
                    else report_mismatch("o_core_tx_last", prev_last, o_core_tx_last);
            end
            if (o_core_tx_valid && i_core_tx_ready) begin
                if (exp_tx_data.size() == 0) begin
                    report_error("core transmit beat with no user beat behind it");
                end else begin
                    assert (o_core_tx_data === exp_tx_data[0])
                        else report_mismatch("o_core_tx_data", exp_tx_data[0], o_core_tx_data);
                    assert (o_core_tx_keep === exp_tx_keep[0])
                        else report_mismatch("o_core_tx_keep", exp_tx_keep[0], o_core_tx_keep);
                    assert (o_core_tx_last === exp_tx_last[0])
                        else report_mismatch("o_core_tx_last", exp_tx_last[0], o_core_tx_last);
                    void'(exp_tx_data.pop_front());
                    void'(exp_tx_keep.pop_front());
                    void'(exp_tx_last.pop_front());
                end
            end
            prev_stall = o_core_tx_valid && !i_core_tx_ready;
            prev_data = o_core_tx_data;
            prev_keep = o_core_tx_keep;
            prev_last = o_core_tx_last;
        end

        // Subsystem reset reaches the stream logic one cycle later
        sub_rst_m = rst || i_user_reset || i_soft_rst_subsys;

        rng_ready = xorshift32(rng_ready);
        i_core_tx_ready <= bp_mode ? rng_ready[7] : 1'b1;
    end

    // --------------------
    // Stimulus tasks
    // --------------------

    task automatic send_rx_tlp(int ndw);
        int left;
        int n;
        logic [31:0] r;
        left = ndw;
        while (left > 0) begin
            r = next_rand();
            n = (left >= 2 && r[0]) ? 2 : 1;
            i_core_rx_data  <= {next_rand(), next_rand()};
            i_core_rx_keep  <= (n == 2) ? tlp_stream_pkg::KEEP_TWO_DW
                                        : tlp_stream_pkg::KEEP_ONE_DW;
            i_core_rx_last  <= (left == n);
            i_core_rx_user  <= r[31:10];
            i_core_rx_valid <= 1'b1;
            @(posedge clk_pcie);
            left -= n;
            if (r[3:2] == 2'b00) begin
                i_core_rx_valid <= 1'b0;
                @(posedge clk_pcie);
            end
        end
        i_core_rx_valid <= 1'b0;
    endtask

    task automatic wait_rx_drained();
        int t;
        t = 0;
        do begin
            @(negedge clk_pcie);
            t++;
        end while ((exp_rx_valid || acc_cnt != 0) && t < TIMEOUT);
        if (t >= TIMEOUT) begin
            report_error("timeout waiting for the receive beat to drain");
        end
        @(posedge clk_pcie);
    endtask

    task automatic send_tx_beats(int count);
        int n;
        int t;
        bit accepted;
        logic [31:0] r;
        for (int k = 0; k < count; k++) begin
            r = next_rand();
            n = 1 + int'(r[1:0]);
            i_tx_tdata   <= {next_rand(), next_rand(), next_rand(), next_rand()};
            i_tx_tkeepdw <= 4'((1 << n) - 1);
            i_tx_tlast   <= r[2];
            i_tx_tvalid  <= 1'b1;
            accepted = 1'b0;
            t = 0;
            while (!accepted && t < TIMEOUT) begin
                @(posedge clk_pcie);
                accepted = o_tx_tready;
                t++;
            end
            if (!accepted) begin
                report_error("timeout waiting for o_tx_tready");
            end
        end
        i_tx_tvalid <= 1'b0;
    endtask

    task automatic wait_tx_drained();
        int t;
        t = 0;
        do begin
            @(negedge clk_pcie);
            t++;
        end while ((exp_tx_data.size() != 0 || o_core_tx_valid) && t < TIMEOUT);
        if (t >= TIMEOUT) begin
            report_error("timeout waiting for the core transmit stream to drain");
        end
        @(posedge clk_pcie);
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int t;
        i_perst_n = 1'b1;
        i_user_reset = 1'b0;
        i_soft_rst_subsys = 1'b0;
        i_soft_rst_core = 1'b0;
        i_user_lnk_up = 1'b0;
        i_core_rx_data = '0;
        i_core_rx_keep = '0;
        i_core_rx_last = 1'b0;
        i_core_rx_valid = 1'b0;
        i_core_rx_user = '0;
        i_tx_tdata = '0;
        i_tx_tkeepdw = '0;
        i_tx_tlast = 1'b0;
        i_tx_tvalid = 1'b0;
        i_core_tx_ready = 1'b1;

        // Registers settle after two edges of reset
        t = 0;
        do begin
            @(negedge clk_pcie);
            t++;
            if (t > 2) begin
                assert (o_rx_tvalid === 1'b0) else report_mismatch("o_rx_tvalid", 0, o_rx_tvalid);
                assert (o_core_tx_valid === 1'b0)
                    else report_mismatch("o_core_tx_valid", 0, o_core_tx_valid);
                assert (o_led_state === 1'b0) else report_mismatch("o_led_state", 0, o_led_state);
                assert (o_core_rst_n === 1'b0)
                    else report_mismatch("o_core_rst_n", 0, o_core_rst_n);
            end
        end while ((rst || t < 4) && t < TIMEOUT);
        if (t >= TIMEOUT) begin
            report_error("reset never released");
        end
        @(posedge clk_pcie);
        finish_test("reset state");

        for (int i = 0; i < 40; i++) begin
            send_rx_tlp(1 + (next_rand() % 12));
        end
        wait_rx_drained();
        finish_test("receive packing");

        bp_mode <= 1'b0;
        send_tx_beats(60);
        wait_tx_drained();
        finish_test("transmit without back-pressure");

        bp_mode <= 1'b1;
        send_tx_beats(60);
        wait_tx_drained();
        bp_mode <= 1'b0;
        finish_test("transmit under back-pressure");

        i_perst_n <= 1'b0;
        @(negedge clk_pcie);
        assert (o_core_rst_n === 1'b1) else report_mismatch("o_core_rst_n", 1, o_core_rst_n);
        @(posedge clk_pcie);
        @(negedge clk_pcie);
        assert (o_core_rst_n === 1'b0) else report_mismatch("o_core_rst_n", 0, o_core_rst_n);
        @(posedge clk_pcie);
        i_perst_n <= 1'b1;
        i_soft_rst_core <= 1'b1;
        @(posedge clk_pcie);
        i_soft_rst_core <= 1'b0;
        @(negedge clk_pcie);
        assert (o_core_rst_n === 1'b0) else report_mismatch("o_core_rst_n", 0, o_core_rst_n);
        @(posedge clk_pcie);
        @(negedge clk_pcie);
        assert (o_core_rst_n === 1'b1) else report_mismatch("o_core_rst_n", 1, o_core_rst_n);
        @(posedge clk_pcie);

        // One packed beat out and a half-packed one held, then a subsystem soft reset
        i_core_rx_data  <= {next_rand(), next_rand()};
        i_core_rx_keep  <= tlp_stream_pkg::KEEP_TWO_DW;
        i_core_rx_last  <= 1'b0;
        i_core_rx_valid <= 1'b1;
        @(posedge clk_pcie);
        i_core_rx_data  <= {next_rand(), next_rand()};
        i_core_rx_keep  <= tlp_stream_pkg::KEEP_ONE_DW;
        @(posedge clk_pcie);
        i_core_rx_data  <= {next_rand(), next_rand()};
        @(posedge clk_pcie);
        i_core_rx_valid   <= 1'b0;
        i_soft_rst_subsys <= 1'b1;
        @(posedge clk_pcie);
        i_soft_rst_subsys <= 1'b0;
        @(posedge clk_pcie);
        @(posedge clk_pcie);
        send_rx_tlp(5);
        wait_rx_drained();

        i_user_lnk_up <= 1'b1;
        @(posedge clk_pcie);
        @(negedge clk_pcie);
        assert (o_led_state === 1'b1) else report_mismatch("o_led_state", 1, o_led_state);
        @(posedge clk_pcie);
        finish_test("reset and LED control");

        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/tlp_stream_pkg.sv
src/tlp_rx_packer.sv
src/tlp_tx_splitter.sv
src/pcie_link_ctrl.sv
src/pcie_tlp_bridge.sv
verif/tb_clock.sv
verif/tb_pcie_tlp_bridge.sv
